/* project.f */
rtl/alu_pkg.sv
rtl/alu_dec_if.sv
rtl/alu_res_if.sv
rtl/alu_decode.sv
rtl/alu_shift.sv
rtl/alu_execute.sv
rtl/alu_result.sv
rtl/alu_top.sv
tb/alu_clk_gen.sv
tb/alu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/alu_tb.sv */
`timescale 1ns/10ps

module alu_tb import alu_pkg::*; ();

    typedef struct packed {
        logic [word_w-1:0] op1;
        logic [word_w-1:0] op2;
        logic [word_w-1:0] op3;
        logic [aluk_w-1:0] aluk;
        size_e             size;
        logic              mask_imm;
        logic              shf_one;
        logic              cf;
        logic              af;
        logic              of;
    } stim_t;

    // flag order cf pf af zf sf of df
    // strobe order swap cc_inval
    typedef struct packed {
        int                idx;
        logic [aluk_w-1:0] aluk;
        alu_word_u         result;
        logic [6:0]        flags;
        logic [1:0]        strobes;
    } exp_t;

    logic              clk;
    logic              arst_n;
    logic [word_w-1:0] op1;
    logic [word_w-1:0] op2;
    logic [word_w-1:0] op3;
    logic [aluk_w-1:0] aluk;
    size_e             size;
    logic              mask_imm;
    logic              shf_one;
    logic              cf;
    logic              af;
    logic              of;
    logic [word_w-1:0] alu_out;
    logic              cf_out;
    logic              pf_out;
    logic              af_out;
    logic              zf_out;
    logic              sf_out;
    logic              of_out;
    logic              df_out;
    logic              swap;
    logic              cc_inval;
    alu_word_u         out_word;

    stim_t stim_q[$];
    exp_t  exp_q[$];
    int    seed = 54;
    int    n_random = 2000;
    logic  stim_ready = 1'b0;

    assign out_word.word = alu_out;

    alu_clk_gen u_clk_gen (.clk(clk));

    alu_top DUT (
        .clk(clk), .arst_n(arst_n), .op1(op1), .op2(op2), .op3(op3),
        .aluk(aluk), .size(size), .mask_imm(mask_imm), .shf_one(shf_one),
        .cf(cf), .af(af), .of(of), .alu_out(alu_out), .cf_out(cf_out),
        .pf_out(pf_out), .af_out(af_out), .zf_out(zf_out), .sf_out(sf_out),
        .of_out(of_out), .df_out(df_out), .swap(swap), .cc_inval(cc_inval)
    );

    //////////////////////////////////////////////////
    // error reporting and compare tasks
    //////////////////////////////////////////////////
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input alu_word_u got, input alu_word_u want, input string what);
        if (got !== want) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s result got %h expected %h",
                               $time, what, got.word, want.word));
        end
    endtask

    task automatic check_flags(input logic [6:0] got, input logic [6:0] want,
                               input string what);
        if (got !== want) begin
            fail_run($sformatf(
                "CHECK FAILED at %0t: %s flags cf,pf,af,zf,sf,of,df got %b expected %b",
                $time, what, got, want));
        end
    endtask

    task automatic check_strobe(input logic [1:0] got, input logic [1:0] want,
                                input string what);
        if (got !== want) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s swap,cc_inval got %b expected %b",
                               $time, what, got, want));
        end
    endtask

    task automatic check_zero(input string when);
        check_word(out_word, '0, when);
        check_flags({cf_out, pf_out, af_out, zf_out, sf_out, of_out, df_out}, 7'd0, when);
        check_strobe({swap, cc_inval}, 2'd0, when);
    endtask

    function automatic string describe(input exp_t e);
        return $sformatf("vector %0d opcode %0d", e.idx, e.aluk);
    endfunction

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic exp_t ref_model(input stim_t s, input int idx);
        exp_t              e;
        logic [word_w-1:0] r;
        logic [31:0]       lo;
        longint            sum;
        logic              c, a, o, zf, zf_set, sf, swp, inval, over;
        int                cnt;
        int                pos;
        r      = '0;
        c      = 1'b0;
        a      = 1'b0;
        o      = 1'b0;
        zf     = 1'b0;
        zf_set = 1'b0;
        swp    = 1'b0;
        inval  = 1'b0;
        pos    = 0;
        cnt    = s.shf_one ? 1 : int'(s.op2[4:0]);
        over   = !s.shf_one && (s.op2[7:5] != 3'd0);
        case (s.aluk)
            op_and:  r = s.op1 & (s.mask_imm ? 64'hffff : s.op2);
            op_add: begin
                lo  = s.op1[31:0] + s.op2[31:0];
                r   = {32'd0, lo};
                // the wrapped sum drops below op1 exactly when bit 31 carries out
                c   = lo < s.op1[31:0];
                a   = (5'(s.op1[3:0]) + 5'(s.op2[3:0])) > 5'd15;
                sum = longint'($signed(s.op1[31:0])) + longint'($signed(s.op2[31:0]));
                o   = sum != longint'($signed(sum[31:0]));
            end
            op_bsf: begin
                zf_set = 1'b1;
                zf     = s.op1[31:0] == 32'd0;
                if (!zf) begin
                    while (s.op1[pos] == 1'b0) pos++;
                    r = 64'(pos);
                end
            end
            op_movb: r = s.op2;
            op_mova: r = s.op1;
            op_std:  r = 64'd1;
            op_cmpxchg: begin
                swp    = s.op1[31:0] == s.op3[31:0];
                r      = swp ? s.op2 : s.op1;
                zf_set = 1'b1;
                zf     = swp;
                // borrow means the unsigned minuend was smaller
                c      = s.op1[31:0] < s.op2[31:0];
                a      = s.op1[3:0] < s.op2[3:0];
                sum    = longint'($signed(s.op1[31:0])) - longint'($signed(s.op2[31:0]));
                o      = sum != longint'($signed(sum[31:0]));
            end
            op_not:  r = ~s.op1;
            op_or:   r = s.op1 | s.op2;
            op_paddw: begin
                for (int i = 0; i < 4; i++) begin
                    r[16*i +: 16] = s.op1[16*i +: 16] + s.op2[16*i +: 16];
                end
            end
            op_paddd: begin
                for (int i = 0; i < 2; i++) begin
                    r[32*i +: 32] = s.op1[32*i +: 32] + s.op2[32*i +: 32];
                end
            end
            op_sal, op_sar: begin
                a     = s.af;
                inval = !over && cnt == 0;
                if (over) begin
                    c = s.op1[31];
                    if (s.aluk == op_sar) r = {32'd0, {32{s.op1[31]}}};
                end else if (cnt == 0) begin
                    r = {32'd0, s.op1[31:0]};
                end else if (s.aluk == op_sar) begin
                    lo = $signed(s.op1[31:0]) >>> cnt;
                    r  = {32'd0, lo};
                    c  = s.op1[cnt - 1];
                end else begin
                    lo = s.op1[31:0] << cnt;
                    r  = {32'd0, lo};
                    c  = s.op1[32 - cnt];
                end
                if (!over && cnt == 1) o = (s.aluk == op_sar) ? 1'b0 : s.op1[31] ^ s.op1[30];
                else o = s.of;
            end
            op_cmovc: r = s.cf ? s.op2 : s.op1;
            default:  r = '0;
        endcase
        case (s.size)
            sz_byte:  sf = r[7];
            sz_word:  sf = r[15];
            sz_dword: sf = r[31];
            default:  sf = r[63];
        endcase
        if (!zf_set) zf = (r == '0);
        e.idx         = idx;
        e.aluk        = s.aluk;
        e.result.word = r;
        e.flags       = {c, ~^r[7:0], a, zf, sf, o, s.aluk == op_std};
        e.strobes     = {swp, inval};
        return e;
    endfunction

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    // ctl is mask_imm, shf_one, cf, af, of
    task automatic add_vec(input logic [aluk_w-1:0] k, input logic [word_w-1:0] a, b, c,
                           input size_e sz, input logic [4:0] ctl);
        stim_t s;
        s.op1  = a;
        s.op2  = b;
        s.op3  = c;
        s.aluk = k;
        s.size = sz;
        {s.mask_imm, s.shf_one, s.cf, s.af, s.of} = ctl;
        stim_q.push_back(s);
    endtask

    task automatic build_stimulus();
        logic [word_w-1:0] pa, pb, r1, r2, r3;
        logic [aluk_w-1:0] k;
        size_e             sz;
        pa = 64'hf0f0_1234_8080_ff81;
        pb = 64'h8f0f_ffff_8f0f_00ff;
        for (int i = 0; i < 4; i++) begin
            sz = size_e'(i);
            add_vec(op_and, pa, pb, 64'h0, sz, 5'b00000);
            add_vec(op_and, pa, pb, 64'h0, sz, 5'b10000);
            add_vec(op_and, pa, 64'h0, 64'h0, sz, 5'b00000);
            add_vec(op_or, pa, pb, 64'h0, sz, 5'b00000);
            add_vec(op_not, pa, pb, 64'h0, sz, 5'b00000);
            add_vec(op_mova, pa, pb, 64'h0, sz, 5'b00000);
            add_vec(op_movb, pa, pb, 64'h0, sz, 5'b00000);
            add_vec(op_cld, pa, pb, 64'h0, sz, 5'b00000);
            add_vec(op_std, pa, pb, 64'h0, sz, 5'b00000);
            add_vec(op_cmovc, pa, pb, 64'h0, sz, 5'b00000);
            add_vec(op_cmovc, pa, pb, 64'h0, sz, 5'b00100);
        end
        // signed and unsigned edges of the 32-bit adder
        add_vec(op_add, 64'h7fff_ffff, 64'h1, 64'h0, sz_dword, 5'b00000);
        add_vec(op_add, 64'hffff_ffff, 64'h1, 64'h0, sz_dword, 5'b00000);
        add_vec(op_add, 64'h0000_000f, 64'h1, 64'h0, sz_byte, 5'b00000);
        add_vec(op_add, 64'h8000_0000, 64'h8000_0000, 64'h0, sz_dword, 5'b00000);
        add_vec(op_cmpxchg, 64'h8000_0000, 64'h1, 64'h8000_0000, sz_dword, 5'b00000);
        add_vec(op_cmpxchg, 64'h0, 64'h1, 64'h5, sz_dword, 5'b00000);
        add_vec(op_cmpxchg, 64'h10, 64'h1, 64'hffff_ffff_0000_0010, sz_qword, 5'b00000);
        for (int i = 0; i < 8; i++) begin
            r1 = {$random(seed), $random(seed)};
            r2 = {$random(seed), $random(seed)};
            add_vec(op_add, r1, r2, 64'h0, sz_dword, 5'b00000);
            add_vec(op_cmpxchg, r1, r2, (i % 2 == 1) ? r1 : r2, sz_qword, 5'b00000);
        end
        // lane carries must stay inside their lane
        add_vec(op_paddw, 64'hffff_8000_7fff_0001, 64'h0001_8000_0001_ffff, 64'h0, sz_qword, 5'b0);
        add_vec(op_paddd, 64'hffff_ffff_7fff_ffff, 64'h0000_0001_0000_0001, 64'h0, sz_qword, 5'b0);
        add_vec(op_paddd, 64'h8000_0000_ffff_ffff, 64'h8000_0000_ffff_ffff, 64'h0, sz_qword, 5'b0);
        for (int j = 0; j < 4; j++) begin
            k  = (j % 2 == 1) ? op_sar : op_sal;
            r1 = (j < 2) ? 64'hffff_0000_c000_0001 : 64'h1234_5678_4000_0003;
            add_vec(k, r1, 64'h1f, 64'h0, sz_dword, 5'b01000);
            add_vec(k, r1, 64'h0, 64'h0, sz_dword, 5'b00011);
            add_vec(k, r1, 64'h1, 64'h0, sz_dword, 5'b00001);
            add_vec(k, r1, 64'h1f, 64'h0, sz_dword, 5'b00010);
            add_vec(k, r1, 64'h20, 64'h0, sz_dword, 5'b00001);
            add_vec(k, r1, 64'he5, 64'h0, sz_dword, 5'b00000);
        end
        add_vec(op_bsf, 64'hffff_ffff_0000_0000, 64'h0, 64'h0, sz_dword, 5'b00000);
        add_vec(op_bsf, 64'h0, 64'h0, 64'h0, sz_dword, 5'b00000);
        add_vec(op_bsf, 64'h0008_0000, 64'h0, 64'h0, sz_dword, 5'b00000);
        add_vec(op_bsf, 64'h8000_0000, 64'h0, 64'h0, sz_dword, 5'b00000);
        add_vec(op_bsf, 64'h1, 64'h0, 64'h0, sz_dword, 5'b00000);
        // gaps in the opcode map with all incoming flags set
        for (int i = 0; i < 32; i++) begin
            if (i == 8 || (i >= 13 && i <= 16) || i >= 20) begin
                r1 = {$random(seed), $random(seed)};
                add_vec(5'(i), r1, ~r1, r1, sz_qword, 5'b11111);
            end
        end
        for (int i = 0; i < n_random; i++) begin
            r1 = {$random(seed), $random(seed)};
            r2 = {$random(seed), $random(seed)};
            r3 = {$random(seed), $random(seed)};
            if ($random(seed) % 2 == 0) r3 = r1;
            k  = 5'($random(seed));
            sz = size_e'(2'($random(seed)));
            add_vec(k, r1, r2, r3, sz, 5'($random(seed)));
        end
    endtask

    task automatic drive(input stim_t s);
        op1      <= s.op1;
        op2      <= s.op2;
        op3      <= s.op3;
        aluk     <= s.aluk;
        size     <= s.size;
        mask_imm <= s.mask_imm;
        shf_one  <= s.shf_one;
        cf       <= s.cf;
        af       <= s.af;
        of       <= s.of;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        arst_n   = 1'b0;
        op1      = '0;
        op2      = '0;
        op3      = '0;
        aluk     = '0;
        size     = sz_byte;
        mask_imm = 1'b0;
        shf_one  = 1'b0;
        cf       = 1'b0;
        af       = 1'b0;
        of       = 1'b0;
        build_stimulus();
        stim_ready = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_zero("during reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_zero("directly after reset");
        // expectation is queued on the edge that samples the inputs
        for (int i = 0; i < stim_q.size(); i++) begin
            @(posedge clk);
            if (i > 0) exp_q.push_back(ref_model(stim_q[i-1], i - 1));
            drive(stim_q[i]);
        end
        @(posedge clk);
        exp_q.push_back(ref_model(stim_q[stim_q.size()-1], stim_q.size() - 1));
        @(posedge clk);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d expected results were never compared", exp_q.size()));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        exp_t e;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_word(out_word, e.result, describe(e));
            check_flags({cf_out, pf_out, af_out, zf_out, sf_out, of_out, df_out},
                        e.flags, describe(e));
            check_strobe({swap, cc_inval}, e.strobes, describe(e));
        end
    end

    initial begin
        wait (stim_ready);
        #((stim_q.size() + 20) * 100);
        fail_run($sformatf("timeout: the run did not finish within %0d clock cycles",
                           stim_q.size() + 20));
    end

endmodule

/* tb/alu_clk_gen.sv */
`timescale 1ns/10ps

module alu_clk_gen (
    output logic clk
);

    // 100 ns period, starts low
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

/* rtl/alu_top.sv */
`timescale 1ns/10ps

module alu_top import alu_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [word_w-1:0] op1,
    input  logic [word_w-1:0] op2,
    input  logic [word_w-1:0] op3,
    input  logic [aluk_w-1:0] aluk,
    input  size_e             size,
    input  logic              mask_imm,
    input  logic              shf_one,
    input  logic              cf,
    input  logic              af,
    input  logic              of,
    output logic [word_w-1:0] alu_out,
    output logic              cf_out,
    output logic              pf_out,
    output logic              af_out,
    output logic              zf_out,
    output logic              sf_out,
    output logic              of_out,
    output logic              df_out,
    output logic              swap,
    output logic              cc_inval
);

    alu_dec_if dec_if ();
    alu_res_if res_if ();

    //////////////////////////////////////////////////
    // decode and execute, same cycle
    //////////////////////////////////////////////////
    alu_decode u_decode (
        .aluk     (aluk),
        .mask_imm (mask_imm),
        .shf_one  (shf_one),
        .dec      (dec_if.dec)
    );

    alu_execute u_execute (
        .op1 (op1),
        .op2 (op2),
        .op3 (op3),
        .cf  (cf),
        .af  (af),
        .of  (of),
        .dec (dec_if.exe),
        .res (res_if.exe)
    );

    // registered outputs
    alu_result u_result (
        .clk      (clk),
        .arst_n   (arst_n),
        .size     (size),
        .dec      (dec_if.exe),
        .res      (res_if.res),
        .alu_out  (alu_out),
        .cf_out   (cf_out),
        .pf_out   (pf_out),
        .af_out   (af_out),
        .zf_out   (zf_out),
        .sf_out   (sf_out),
        .of_out   (of_out),
        .df_out   (df_out),
        .swap     (swap),
        .cc_inval (cc_inval)
    );

endmodule

/* rtl/alu_result.sv */
`timescale 1ns/10ps

module alu_result import alu_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  size_e             size,
    alu_dec_if.exe            dec,
    alu_res_if.res            res,
    output logic [word_w-1:0] alu_out,
    output logic              cf_out,
    output logic              pf_out,
    output logic              af_out,
    output logic              zf_out,
    output logic              sf_out,
    output logic              of_out,
    output logic              df_out,
    output logic              swap,
    output logic              cc_inval
);

    logic pf_d;
    logic sf_d;
    logic zf_d;

    //////////////////////////////////////////////////
    // flag generation
    //////////////////////////////////////////////////

    // even parity of the low byte only
    assign pf_d = ~^res.result.word[7:0];

    always_comb begin
        case (size)
            sz_byte:  sf_d = res.result.word[7];
            sz_word:  sf_d = res.result.word[15];
            sz_dword: sf_d = res.result.word[31];
            default:  sf_d = res.result.word[63];
        endcase
    end

    always_comb begin
        case (dec.zf_src)
            zf_bsf:     zf_d = res.bsf_zero;
            zf_cmpxchg: zf_d = res.cmp_eq;
            default:    zf_d = ~|res.result.word;
        endcase
    end

    // output register, one cycle of latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_out  <= '0;
            cf_out   <= 1'b0;
            pf_out   <= 1'b0;
            af_out   <= 1'b0;
            zf_out   <= 1'b0;
            sf_out   <= 1'b0;
            of_out   <= 1'b0;
            df_out   <= 1'b0;
            swap     <= 1'b0;
            cc_inval <= 1'b0;
        end else begin
            alu_out  <= res.result.word;
            cf_out   <= res.cf;
            pf_out   <= pf_d;
            af_out   <= res.af;
            zf_out   <= zf_d;
            sf_out   <= sf_d;
            of_out   <= res.of;
            df_out   <= dec.is_std;
            swap     <= res.cmp_eq & dec.is_cmpxchg;
            // zero count leaves the flags untouched
            cc_inval <= dec.is_shift & res.shift_cnt_zero;
        end
    end

endmodule

/* rtl/alu_execute.sv */
`timescale 1ns/10ps

module alu_execute import alu_pkg::*; (
    input  logic [word_w-1:0] op1,
    input  logic [word_w-1:0] op2,
    input  logic [word_w-1:0] op3,
    input  logic              cf,
    input  logic              af,
    input  logic              of,
    alu_dec_if.exe            dec,
    alu_res_if.exe            res
);

    logic [word_w-1:0]    unit_res [num_units];
    logic [num_units-1:0] unit_cf;
    logic [num_units-1:0] unit_af;
    logic [num_units-1:0] unit_of;
    alu_word_u            a;
    alu_word_u            b;
    alu_word_u            paddw_res;
    alu_word_u            paddd_res;
    logic [32:0]          add_sum;
    logic [32:0]          sub_diff;
    logic [4:0]           bsf_idx;
    logic [word_w-1:0]    shf_res;
    logic                 shf_cf;
    logic                 shf_of;

    assign a.word = op1;
    assign b.word = op2;

    //////////////////////////////////////////////////
    // arithmetic units
    //////////////////////////////////////////////////
    assign add_sum  = {1'b0, op1[31:0]} + {1'b0, op2[31:0]};
    assign sub_diff = {1'b0, op1[31:0]} - {1'b0, op2[31:0]};

    // lanes wrap on their own
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            paddw_res.w16[i] = a.w16[i] + b.w16[i];
        end
        for (int i = 0; i < 2; i++) begin
            paddd_res.w32[i] = a.w32[i] + b.w32[i];
        end
    end

    // lowest set bit wins, so scan downward
    always_comb begin
        bsf_idx = '0;
        for (int i = 31; i >= 0; i--) begin
            if (op1[i]) bsf_idx = 5'(i);
        end
    end

    alu_shift u_shift (
        .op1      (op1),
        .op2      (op2),
        .shf_one  (dec.shf_one),
        .arith    (dec.unit_sel[u_sar]),
        .of       (of),
        .result   (shf_res),
        .cf       (shf_cf),
        .of_out   (shf_of),
        .cnt_zero (res.shift_cnt_zero)
    );

    assign res.bsf_zero = ~|op1[31:0];
    assign res.cmp_eq   = (op1[31:0] == op3[31:0]);

    //////////////////////////////////////////////////
    // per-unit results and flags
    //////////////////////////////////////////////////
    always_comb begin
        unit_res[u_and]     = op1 & (dec.mask_imm ? and_mask : op2);
        unit_res[u_add]     = {32'd0, add_sum[31:0]};
        unit_res[u_bsf]     = res.bsf_zero ? '0 : word_w'(bsf_idx);
        unit_res[u_movb]    = op2;
        unit_res[u_mova]    = op1;
        unit_res[u_cld]     = '0;
        unit_res[u_std]     = word_w'(1);
        unit_res[u_cmpxchg] = res.cmp_eq ? op2 : op1;
        unit_res[u_not]     = ~op1;
        unit_res[u_or]      = op1 | op2;
        unit_res[u_paddw]   = paddw_res.word;
        unit_res[u_paddd]   = paddd_res.word;
        unit_res[u_sar]     = shf_res;
        unit_res[u_sal]     = shf_res;
        unit_res[u_cmovc]   = cf ? op2 : op1;

        unit_cf = '0;
        unit_af = '0;
        unit_of = '0;
        unit_cf[u_add]     = add_sum[32];
        unit_af[u_add]     = op1[4] ^ op2[4] ^ add_sum[4];
        unit_of[u_add]     = (op1[31] == op2[31]) & (add_sum[31] != op1[31]);
        unit_cf[u_cmpxchg] = sub_diff[32];
        unit_af[u_cmpxchg] = op1[4] ^ op2[4] ^ sub_diff[4];
        unit_of[u_cmpxchg] = (op1[31] != op2[31]) & (sub_diff[31] != op1[31]);
        // shifts leave af as it came in
        unit_cf[u_sar]     = shf_cf;
        unit_af[u_sar]     = af;
        unit_of[u_sar]     = shf_of;
        unit_cf[u_sal]     = shf_cf;
        unit_af[u_sal]     = af;
        unit_of[u_sal]     = shf_of;
    end

    // one-hot select, nothing passes for an invalid opcode
    always_comb begin
        res.result.word = '0;
        if (dec.valid_op) begin
            for (int i = 0; i < num_units; i++) begin
                if (dec.unit_sel[i]) res.result.word = res.result.word | unit_res[i];
            end
        end
        res.cf = |(unit_cf & dec.unit_sel);
        res.af = |(unit_af & dec.unit_sel);
        res.of = |(unit_of & dec.unit_sel);
    end

endmodule

/* rtl/alu_shift.sv */
`timescale 1ns/10ps

module alu_shift import alu_pkg::*; (
    input  logic [word_w-1:0] op1,
    input  logic [word_w-1:0] op2,
    input  logic              shf_one,
    input  logic              arith,
    input  logic              of,
    output logic [word_w-1:0] result,
    output logic              cf,
    output logic              of_out,
    output logic              cnt_zero
);

    logic [shift_cnt_w-1:0] cnt;
    logic                   over;
    logic [32:0]            sal_ext;
    logic [32:0]            sar_ext;
    logic [31:0]            shf_res;

    //////////////////////////////////////////////////
    // count selection
    //////////////////////////////////////////////////
    always_comb begin
        cnt  = shf_one ? shift_cnt_w'(1) : op2[shift_cnt_w-1:0];
        // count field only covers 0..31
        over = ~shf_one & (|op2[7:5]);
    end

    // one extra bit on the exit side catches the last bit out
    assign sal_ext = {1'b0, op1[31:0]} << cnt;
    assign sar_ext = 33'($signed({op1[31:0], 1'b0}) >>> cnt);

    always_comb begin
        if (over) begin
            shf_res = arith ? {32{op1[31]}} : 32'd0;
            cf      = op1[31];
        end else if (arith) begin
            shf_res = sar_ext[32:1];
            cf      = sar_ext[0];
        end else begin
            shf_res = sal_ext[31:0];
            cf      = sal_ext[32];
        end
    end

    assign result = {32'd0, shf_res};

    // of only defined for single-bit shifts, kept otherwise
    always_comb begin
        if (!over && cnt == shift_cnt_w'(1)) begin
            of_out = arith ? 1'b0 : (op1[31] ^ op1[30]);
        end else begin
            of_out = of;
        end
    end

    assign cnt_zero = (cnt == '0) & ~over;

endmodule

/* rtl/alu_decode.sv */
`timescale 1ns/10ps

module alu_decode import alu_pkg::*; (
    input  logic [aluk_w-1:0] aluk,
    input  logic              mask_imm,
    input  logic              shf_one,
    alu_dec_if.dec            dec
);

    always_comb begin
        dec.unit_sel   = '0;
        dec.zf_src     = zf_result;
        dec.mask_imm   = 1'b0;
        dec.shf_one    = 1'b0;
        dec.is_cmpxchg = 1'b0;
        dec.is_shift   = 1'b0;
        dec.is_std     = 1'b0;
        dec.valid_op   = 1'b1;

        case (aluk)
            op_and: begin
                dec.unit_sel[u_and] = 1'b1;
                dec.mask_imm        = mask_imm;
            end
            op_add:   dec.unit_sel[u_add]  = 1'b1;
            op_bsf: begin
                dec.unit_sel[u_bsf] = 1'b1;
                dec.zf_src          = zf_bsf;
            end
            op_movb:  dec.unit_sel[u_movb] = 1'b1;
            op_mova:  dec.unit_sel[u_mova] = 1'b1;
            op_cld:   dec.unit_sel[u_cld]  = 1'b1;
            op_std: begin
                dec.unit_sel[u_std] = 1'b1;
                dec.is_std          = 1'b1;
            end
            op_cmpxchg: begin
                dec.unit_sel[u_cmpxchg] = 1'b1;
                dec.zf_src              = zf_cmpxchg;
                dec.is_cmpxchg          = 1'b1;
            end
            op_not:   dec.unit_sel[u_not]   = 1'b1;
            op_or:    dec.unit_sel[u_or]    = 1'b1;
            op_paddw: dec.unit_sel[u_paddw] = 1'b1;
            op_paddd: dec.unit_sel[u_paddd] = 1'b1;
            // both shifts share the count-of-one select
            op_sar, op_sal: begin
                dec.unit_sel[u_sar] = (aluk == op_sar);
                dec.unit_sel[u_sal] = (aluk == op_sal);
                dec.is_shift        = 1'b1;
                dec.shf_one         = shf_one;
            end
            op_cmovc: dec.unit_sel[u_cmovc] = 1'b1;
            default:  dec.valid_op = 1'b0;
        endcase
    end

endmodule

/* rtl/alu_res_if.sv */
`timescale 1ns/10ps

interface alu_res_if import alu_pkg::*; ();

    alu_word_u result;
    logic      cf;
    logic      af;
    logic      of;
    // raw status for the flag logic in the result stage
    logic      bsf_zero;
    logic      cmp_eq;
    logic      shift_cnt_zero;

    modport exe (
        output result, cf, af, of,
        output bsf_zero, cmp_eq, shift_cnt_zero
    );

    modport res (
        input result, cf, af, of,
        input bsf_zero, cmp_eq, shift_cnt_zero
    );

endinterface

/* rtl/alu_dec_if.sv */
`timescale 1ns/10ps

interface alu_dec_if import alu_pkg::*; ();

    logic [num_units-1:0] unit_sel;
    zf_src_e              zf_src;
    logic                 mask_imm;
    logic                 shf_one;
    logic                 is_cmpxchg;
    logic                 is_shift;
    logic                 is_std;
    logic                 valid_op;

    // decode drives, execute and result read
    modport dec (
        output unit_sel, zf_src, mask_imm, shf_one,
        output is_cmpxchg, is_shift, is_std, valid_op
    );

    modport exe (
        input unit_sel, zf_src, mask_imm, shf_one,
        input is_cmpxchg, is_shift, is_std, valid_op
    );

endinterface

/* rtl/alu_pkg.sv */
package alu_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int word_w      = 64;
    localparam int aluk_w      = 5;
    localparam int num_units   = 15;
    localparam int shift_cnt_w = 5;

    // opcode encoding, gaps are invalid codes
    typedef enum logic [aluk_w-1:0] {
        op_and     = 5'd0,
        op_add     = 5'd1,
        op_bsf     = 5'd2,
        op_movb    = 5'd3,
        op_mova    = 5'd4,
        op_cld     = 5'd5,
        op_std     = 5'd6,
        op_cmpxchg = 5'd7,
        op_not     = 5'd9,
        op_or      = 5'd10,
        op_paddw   = 5'd11,
        op_paddd   = 5'd12,
        op_sar     = 5'd17,
        op_sal     = 5'd18,
        op_cmovc   = 5'd19
    } alu_op_e;

    // bit positions in the one-hot unit select
    localparam int u_and     = 0;
    localparam int u_add     = 1;
    localparam int u_bsf     = 2;
    localparam int u_movb    = 3;
    localparam int u_mova    = 4;
    localparam int u_cld     = 5;
    localparam int u_std     = 6;
    localparam int u_cmpxchg = 7;
    localparam int u_not     = 8;
    localparam int u_or      = 9;
    localparam int u_paddw   = 10;
    localparam int u_paddd   = 11;
    localparam int u_sar     = 12;
    localparam int u_sal     = 13;
    localparam int u_cmovc   = 14;

    typedef enum logic [1:0] {sz_byte, sz_word, sz_dword, sz_qword} size_e;

    typedef enum logic [1:0] {zf_result, zf_bsf, zf_cmpxchg} zf_src_e;

    // one operand word, seen whole or as packed lanes
    typedef union packed {
        logic [word_w-1:0] word;
        logic [3:0][15:0]  w16;
        logic [1:0][31:0]  w32;
    } alu_word_u;

    localparam logic [word_w-1:0] and_mask = 64'h0000_0000_0000_ffff;

endpackage
